//--- rtl/video_pkg.sv
// shared widths, video pixel and AXI4-Lite types for the binning stage
`default_nettype none

package video_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int PIXEL_WIDTH    = 8;
    localparam int LINE_SIZE_MAX  = 64;
    localparam int LINE_PTR_WIDTH = $clog2(LINE_SIZE_MAX);
    localparam int AXI_ADDR_WIDTH = 4;
    localparam int AXI_DATA_WIDTH = 32;

    // one pixel with its de/hs/vs flags
    typedef struct packed {
        logic [PIXEL_WIDTH-1:0] data;
        logic                   de;
        logic                   hs;
        logic                   vs;
    } video_px_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // master side of the register port
    typedef struct packed {
        logic                        awvalid;
        logic [AXI_ADDR_WIDTH-1:0]   awaddr;
        logic                        wvalid;
        logic [AXI_DATA_WIDTH-1:0]   wdata;
        logic [AXI_DATA_WIDTH/8-1:0] wstrb;
        logic                        bready;
        logic                        arvalid;
        logic [AXI_ADDR_WIDTH-1:0]   araddr;
        logic                        rready;
    } axil_req_t;

    // slave side of the register port
    typedef struct packed {
        logic                      awready;
        logic                      wready;
        logic                      bvalid;
        axil_resp_e                bresp;
        logic                      arready;
        logic                      rvalid;
        logic [AXI_DATA_WIDTH-1:0] rdata;
        axil_resp_e                rresp;
    } axil_rsp_t;

    // register map
    typedef enum logic [AXI_ADDR_WIDTH-1:0] {
        REG_CTRL      = 4'h0,
        REG_FRAME_CNT = 4'h4,
        REG_PIXEL_CNT = 4'h8
    } reg_addr_e;

endpackage

`default_nettype wire

//--- rtl/binning_2x2.sv
// 2x2 pixel binning core with one line buffer and frame-aligned bypass
`timescale 1ns/100ps
`default_nettype none

module binning_2x2 import video_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n_i,
    input  wire logic      bypass_i,
    input  wire video_px_t vid_i,
    output video_px_t      vid_o
);

    // ----------------------------------------
    // line buffer and line tracking
    // ----------------------------------------
    logic [PIXEL_WIDTH-1:0]    line_mem [LINE_SIZE_MAX];
    logic [LINE_PTR_WIDTH-1:0] col_ptr;
    logic                      hs_q;
    logic                      line_odd;

    // stage 0: current pixel and the pixel above it
    logic [PIXEL_WIDTH-1:0] cur_px;
    logic [PIXEL_WIDTH-1:0] top_px;
    logic                   s0_de;
    logic                   s0_pair;

    // stage 1: horizontal pair sums
    logic [PIXEL_WIDTH-1:0] cur_prev;
    logic [PIXEL_WIDTH-1:0] top_prev;
    logic [PIXEL_WIDTH:0]   sum_cur;
    logic [PIXEL_WIDTH:0]   sum_top;
    logic                   s1_vld;

    // stage 2: full 2x2 sum
    logic [PIXEL_WIDTH+1:0] sum_all;
    logic                   s2_vld;

    // binned output and rebuilt flags
    logic [PIXEL_WIDTH-1:0] bin_data;
    logic                   bin_de;
    logic [3:0]             sr_hs;
    logic [3:0]             sr_vs;

    // bypass path
    logic      bypass_q;
    video_px_t pass_q;

    // column pointer restarts every line, parity restarts every frame
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            col_ptr  <= '0;
            hs_q     <= 1'b0;
            line_odd <= 1'b0;
        end else begin
            hs_q <= vid_i.hs;
            if (!vid_i.hs) begin
                col_ptr <= '0;
            end else if (vid_i.de) begin
                col_ptr <= col_ptr + 1'b1;
            end
            if (!vid_i.vs) begin
                line_odd <= 1'b0;
            end else if (hs_q && !vid_i.hs) begin
                line_odd <= ~line_odd;
            end
        end
    end

    // ----------------------------------------
    // datapath
    // ----------------------------------------
    always_ff @(posedge clk) begin
        // read the previous line before overwriting the same column
        if (vid_i.de) begin
            top_px            <= line_mem[col_ptr];
            line_mem[col_ptr] <= vid_i.data;
            cur_px            <= vid_i.data;
        end
        if (s0_de) begin
            top_prev <= top_px;
            cur_prev <= cur_px;
            sum_top  <= {1'b0, top_prev} + {1'b0, top_px};
            sum_cur  <= {1'b0, cur_prev} + {1'b0, cur_px};
        end
        sum_all  <= {1'b0, sum_top} + {1'b0, sum_cur};
        // floor of sum / 4
        bin_data <= sum_all[PIXEL_WIDTH+1:2];
    end

    // ----------------------------------------
    // valid and flag pipeline
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s0_de   <= 1'b0;
            s0_pair <= 1'b0;
            s1_vld  <= 1'b0;
            s2_vld  <= 1'b0;
            bin_de  <= 1'b0;
            sr_hs   <= '0;
            sr_vs   <= '0;
        end else begin
            s0_de   <= vid_i.de;
            // odd column on an odd line closes a 2x2 block
            s0_pair <= vid_i.de & line_odd & col_ptr[0];
            s1_vld  <= s0_pair;
            s2_vld  <= s1_vld;
            bin_de  <= s2_vld;
            // output lines exist only on odd input lines
            sr_hs   <= {sr_hs[2:0], vid_i.hs & line_odd};
            sr_vs   <= {sr_vs[2:0], vid_i.vs};
        end
    end

    // ----------------------------------------
    // bypass
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bypass_q <= 1'b0;
            pass_q   <= '0;
        end else begin
            pass_q <= vid_i;
            // mode changes in vertical blanking once the binned tail has left
            if (!vid_i.vs && sr_vs == '0) begin
                bypass_q <= bypass_i;
            end
        end
    end

    always_comb begin
        if (bypass_q) begin
            vid_o = pass_q;
        end else begin
            vid_o.data = bin_data;
            vid_o.de   = bin_de;
            vid_o.hs   = sr_hs[3];
            vid_o.vs   = sr_vs[3];
        end
    end

endmodule

`default_nettype wire

//--- rtl/frame_stats.sv
// output frame statistics: finished frame count and pixels in the last frame
`timescale 1ns/100ps
`default_nettype none

module frame_stats import video_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n_i,
    input  wire video_px_t vid_i,
    output logic [31:0]    frame_cnt_o,
    output logic [31:0]    pixel_cnt_o
);

    logic        vs_q;
    logic        vs_fall;
    // pixels seen so far in the current frame
    logic [31:0] run_cnt;

    // ----------------------------------------
    // frame end detect
    // ----------------------------------------
    assign vs_fall = vs_q & ~vid_i.vs;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vs_q        <= 1'b0;
            run_cnt     <= '0;
            frame_cnt_o <= '0;
            pixel_cnt_o <= '0;
        end else begin
            vs_q <= vid_i.vs;
            if (vs_fall) begin
                // publish the finished frame and start over
                pixel_cnt_o <= run_cnt;
                frame_cnt_o <= frame_cnt_o + 1'b1;
                run_cnt     <= '0;
            end else if (vid_i.de) begin
                run_cnt <= run_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/bin_regs_axil.sv
// AXI4-Lite register slave with the bypass control and statistics readback
`timescale 1ns/100ps
`default_nettype none

module bin_regs_axil import video_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n_i,
    input  wire axil_req_t   axil_req_i,
    output axil_rsp_t        axil_rsp_o,
    input  wire logic [31:0] frame_cnt_i,
    input  wire logic [31:0] pixel_cnt_i,
    output logic             bypass_o
);

    typedef enum logic [1:0] {W_IDLE, W_ACCEPT, W_EXEC, W_RESP} wr_state_e;
    typedef enum logic [1:0] {R_IDLE, R_ACCEPT, R_DATA} rd_state_e;

    wr_state_e                 wr_state;
    rd_state_e                 rd_state;
    logic                      awready;
    logic                      wready;
    logic                      bvalid;
    axil_resp_e                bresp;
    logic                      arready;
    logic                      rvalid;
    logic [AXI_DATA_WIDTH-1:0] rdata;
    axil_resp_e                rresp;

    // captured write request
    logic [AXI_ADDR_WIDTH-1:0] wr_addr;
    logic                      wr_bit0;
    logic                      wr_lane0;

    always_ff @(posedge clk) begin
        if (wr_state == W_ACCEPT) begin
            wr_addr  <= axil_req_i.awaddr;
            wr_bit0  <= axil_req_i.wdata[0];
            wr_lane0 <= axil_req_i.wstrb[0];
        end
    end

    // ----------------------------------------
    // write channel
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_state <= W_IDLE;
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= OKAY;
            bypass_o <= 1'b0;
        end else begin
            case (wr_state)
                W_IDLE: begin
                    // address and data are taken together
                    if (axil_req_i.awvalid && axil_req_i.wvalid) begin
                        awready  <= 1'b1;
                        wready   <= 1'b1;
                        wr_state <= W_ACCEPT;
                    end
                end
                W_ACCEPT: begin
                    awready  <= 1'b0;
                    wready   <= 1'b0;
                    wr_state <= W_EXEC;
                end
                W_EXEC: begin
                    if (wr_addr == REG_CTRL) begin
                        if (wr_lane0) begin
                            bypass_o <= wr_bit0;
                        end
                        bresp <= OKAY;
                    end else begin
                        bresp <= SLVERR;
                    end
                    bvalid   <= 1'b1;
                    wr_state <= W_RESP;
                end
                default: begin
                    if (axil_req_i.bready) begin
                        bvalid   <= 1'b0;
                        wr_state <= W_IDLE;
                    end
                end
            endcase
        end
    end

    // ----------------------------------------
    // read channel
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_state <= R_IDLE;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= OKAY;
        end else begin
            case (rd_state)
                R_IDLE: begin
                    if (axil_req_i.arvalid) begin
                        arready  <= 1'b1;
                        rd_state <= R_ACCEPT;
                    end
                end
                R_ACCEPT: begin
                    arready <= 1'b0;
                    rvalid  <= 1'b1;
                    rresp   <= OKAY;
                    case (axil_req_i.araddr)
                        REG_CTRL:      rdata <= {{(AXI_DATA_WIDTH-1){1'b0}}, bypass_o};
                        REG_FRAME_CNT: rdata <= frame_cnt_i;
                        REG_PIXEL_CNT: rdata <= pixel_cnt_i;
                        default: begin
                            rdata <= '0;
                            rresp <= SLVERR;
                        end
                    endcase
                    rd_state <= R_DATA;
                end
                default: begin
                    if (axil_req_i.rready) begin
                        rvalid   <= 1'b0;
                        rd_state <= R_IDLE;
                    end
                end
            endcase
        end
    end

    always_comb begin
        axil_rsp_o.awready = awready;
        axil_rsp_o.wready  = wready;
        axil_rsp_o.bvalid  = bvalid;
        axil_rsp_o.bresp   = bresp;
        axil_rsp_o.arready = arready;
        axil_rsp_o.rvalid  = rvalid;
        axil_rsp_o.rdata   = rdata;
        axil_rsp_o.rresp   = rresp;
    end

endmodule

`default_nettype wire

//--- rtl/binning_top.sv
// binning stage top: core, output statistics and AXI4-Lite register block
`timescale 1ns/100ps
`default_nettype none

module binning_top import video_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n_i,
    input  wire video_px_t vid_i,
    output video_px_t      vid_o,
    input  wire axil_req_t axil_req_i,
    output axil_rsp_t      axil_rsp_o
);

    logic        bypass;
    logic [31:0] frame_cnt;
    logic [31:0] pixel_cnt;

    // ----------------------------------------
    // video path
    // ----------------------------------------
    binning_2x2 binning_2x2_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .bypass_i (bypass),
        .vid_i    (vid_i),
        .vid_o    (vid_o)
    );

    // statistics watch the core output
    frame_stats frame_stats_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .vid_i       (vid_o),
        .frame_cnt_o (frame_cnt),
        .pixel_cnt_o (pixel_cnt)
    );

    // ----------------------------------------
    // register port
    // ----------------------------------------
    bin_regs_axil bin_regs_axil_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o),
        .frame_cnt_i (frame_cnt),
        .pixel_cnt_i (pixel_cnt),
        .bypass_o    (bypass)
    );

endmodule

`default_nettype wire

//--- verification/binning_tb.sv
// directed testbench for the 2x2 binning stage and its AXI4-Lite registers
`timescale 1ns/100ps
`default_nettype none

module binning_tb import video_pkg::*; ();

    logic      clk;
    logic      rst_n_i;
    video_px_t vid_in;
    video_px_t vid_out;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;

    int                     pass_cnt;
    int                     fail_cnt;
    int                     err_cnt;
    int                     cycle_cnt;
    int                     cycle_limit;
    int                     stray_cnt;
    int                     line_cnt;
    logic                   out_hs_q;
    logic [15:0]            lfsr_state;
    logic [PIXEL_WIDTH-1:0] sent_q[$];
    logic [PIXEL_WIDTH-1:0] out_q[$];

    binning_top binning_top_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .vid_i      (vid_in),
        .vid_o      (vid_out),
        .axil_req_i (axil_req),
        .axil_rsp_o (axil_rsp)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // output monitor, sampled away from the active edge
    always @(negedge clk) begin
        // one output line per rising hs
        if (rst_n_i && vid_out.hs && !out_hs_q) begin
            line_cnt++;
        end
        out_hs_q = vid_out.hs;
        if (rst_n_i && vid_out.de) begin
            out_q.push_back(vid_out.data);
            if (!vid_out.vs || !vid_out.hs) begin
                stray_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("run stopped: tests still busy after %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic draw_pixel(output logic [PIXEL_WIDTH-1:0] value);
        int bit_idx;
        value = '0;
        for (bit_idx = 0; bit_idx < PIXEL_WIDTH; bit_idx++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[PIXEL_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    function automatic int frame_cycles(input int width, input int height);
        return 4 + height * (2 * width + 3) + 10;
    endfunction

    task automatic drive_video(input video_px_t px);
        @(posedge clk);
        vid_in <= px;
    endtask

    // sparse pixels, hs across each line, vs low around the frame
    task automatic send_frame(input int width, input int height);
        video_px_t              px;
        logic [PIXEL_WIDTH-1:0] value;
        int                     row;
        int                     col;
        px = '0;
        repeat (2) drive_video(px);
        px.vs = 1'b1;
        repeat (2) drive_video(px);
        for (row = 0; row < height; row++) begin
            px.hs = 1'b1;
            for (col = 0; col < width; col++) begin
                draw_pixel(value);
                sent_q.push_back(value);
                px.data = value;
                px.de   = 1'b1;
                drive_video(px);
                px.de = 1'b0;
                drive_video(px);
            end
            px.hs   = 1'b0;
            px.data = '0;
            repeat (3) drive_video(px);
        end
        // blanking long enough to flush the binning pipeline
        px.vs = 1'b0;
        repeat (10) drive_video(px);
    endtask

    task automatic axil_write(input logic [AXI_ADDR_WIDTH-1:0] addr,
                              input logic [AXI_DATA_WIDTH-1:0] data,
                              output axil_resp_e resp);
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= '1;
        axil_req.bready  <= 1'b1;
        @(negedge clk);
        while (!axil_rsp.awready) @(negedge clk);
        if (!axil_rsp.wready) begin
            $display("wready did not rise together with awready at %0t", $time);
            err_cnt++;
        end
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.bvalid) @(negedge clk);
        resp = axil_rsp.bresp;
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [AXI_ADDR_WIDTH-1:0] addr,
                             output logic [AXI_DATA_WIDTH-1:0] data,
                             output axil_resp_e resp);
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        axil_req.rready  <= 1'b1;
        @(negedge clk);
        while (!axil_rsp.arready) @(negedge clk);
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.rvalid) @(negedge clk);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_pixel(input string name, input logic [PIXEL_WIDTH-1:0] expected,
                               input logic [PIXEL_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_e expected,
                              input axil_resp_e actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %s, got %s", $time, name,
                     expected.name(), actual.name());
            err_cnt++;
        end
    endtask

    task automatic check_word(input string name, input logic [AXI_DATA_WIDTH-1:0] expected,
                              input logic [AXI_DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            err_cnt++;
        end
    endtask

    // floor of each 2x2 block average, in raster order
    task automatic check_binned(input int width, input int height);
        int                     row;
        int                     col;
        int                     base;
        int                     sum;
        logic [PIXEL_WIDTH-1:0] expected;
        check_word("output line count", height / 2, line_cnt);
        check_word("binned pixel count", width * height / 4, out_q.size());
        if (out_q.size() == width * height / 4) begin
            for (row = 0; row < height / 2; row++) begin
                for (col = 0; col < width / 2; col++) begin
                    base = 2 * row * width + 2 * col;
                    sum  = sent_q[base] + sent_q[base + 1]
                         + sent_q[base + width] + sent_q[base + width + 1];
                    expected = PIXEL_WIDTH'(sum / 4);
                    check_pixel("vid_o.data", expected, out_q[row * (width / 2) + col]);
                end
            end
        end
    endtask

    task automatic check_passthrough();
        int idx;
        check_word("bypass pixel count", sent_q.size(), out_q.size());
        if (out_q.size() == sent_q.size()) begin
            for (idx = 0; idx < sent_q.size(); idx++) begin
                check_pixel("vid_o.data", sent_q[idx], out_q[idx]);
            end
        end
    endtask

    task automatic clear_queues();
        sent_q.delete();
        out_q.delete();
        stray_cnt = 0;
        line_cnt  = 0;
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == 0) begin
            $display("%s: ok", name);
            pass_cnt++;
        end else begin
            $display("Fail: %s with %0d errors", name, err_cnt);
            fail_cnt++;
        end
        err_cnt = 0;
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic test_registers();
        axil_resp_e                resp;
        logic [AXI_DATA_WIDTH-1:0] data;
        axil_write(REG_CTRL, 32'd1, resp);
        check_resp("bresp", OKAY, resp);
        axil_read(REG_CTRL, data, resp);
        check_resp("rresp", OKAY, resp);
        check_word("rdata", 32'd1, data);
        // rejected writes leave every register alone
        axil_write(REG_FRAME_CNT, 32'h5a, resp);
        check_resp("bresp", SLVERR, resp);
        axil_read(REG_FRAME_CNT, data, resp);
        check_word("rdata", 32'd0, data);
        axil_write(4'hc, 32'd0, resp);
        check_resp("bresp", SLVERR, resp);
        axil_read(REG_CTRL, data, resp);
        check_word("rdata", 32'd1, data);
        axil_read(4'hc, data, resp);
        check_resp("rresp", SLVERR, resp);
        check_word("rdata", 32'd0, data);
        axil_write(REG_CTRL, 32'd0, resp);
        check_resp("bresp", OKAY, resp);
        finish_test("register access");
    endtask

    task automatic test_binning();
        clear_queues();
        send_frame(16, 8);
        check_binned(16, 8);
        if (stray_cnt != 0) begin
            $display("%0d output pixels appeared outside hs or vs", stray_cnt);
            err_cnt++;
        end
        finish_test("binning 16x8");
    endtask

    task automatic test_bypass();
        axil_resp_e resp;
        axil_write(REG_CTRL, 32'd1, resp);
        check_resp("bresp", OKAY, resp);
        clear_queues();
        send_frame(16, 8);
        check_passthrough();
        finish_test("bypass 16x8");
    endtask

    task automatic test_alignment();
        axil_resp_e resp;
        axil_resp_e mid_resp;
        axil_write(REG_CTRL, 32'd0, resp);
        check_resp("bresp", OKAY, resp);
        clear_queues();
        fork
            send_frame(16, 8);
            begin
                // halfway through the frame
                while (sent_q.size() < 64) @(posedge clk);
                axil_write(REG_CTRL, 32'd1, mid_resp);
            end
        join
        check_resp("bresp", OKAY, mid_resp);
        check_binned(16, 8);
        clear_queues();
        send_frame(16, 8);
        check_passthrough();
        finish_test("bypass frame alignment");
    endtask

    task automatic test_statistics();
        axil_resp_e                resp;
        logic [AXI_DATA_WIDTH-1:0] data;
        // four 16x8 frames so far, the last one passed through
        axil_read(REG_FRAME_CNT, data, resp);
        check_word("frame_cnt", 32'd4, data);
        axil_read(REG_PIXEL_CNT, data, resp);
        check_word("pixel_cnt", 32'd128, data);
        axil_write(REG_CTRL, 32'd0, resp);
        check_resp("bresp", OKAY, resp);
        clear_queues();
        send_frame(8, 4);
        axil_read(REG_FRAME_CNT, data, resp);
        check_word("frame_cnt", 32'd5, data);
        axil_read(REG_PIXEL_CNT, data, resp);
        check_word("pixel_cnt", 32'd8, data);
        finish_test("frame statistics");
    endtask

    initial begin
        rst_n_i    = 1'b0;
        vid_in     = '0;
        axil_req   = '0;
        lfsr_state = 16'd29;
        pass_cnt   = 0;
        fail_cnt   = 0;
        err_cnt    = 0;
        cycle_cnt  = 0;
        stray_cnt  = 0;
        line_cnt   = 0;
        out_hs_q   = 1'b0;
        // five frames and about sixteen register accesses, plus half again
        cycle_limit = (2 + 4 * frame_cycles(16, 8) + frame_cycles(8, 4) + 16 * 8) * 3 / 2;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        test_registers();
        test_binning();
        test_bypass();
        test_alignment();
        test_statistics();
        $display("%0d tests ok, %0d tests with errors", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
rtl/video_pkg.sv
rtl/binning_2x2.sv
rtl/frame_stats.sv
rtl/bin_regs_axil.sv
rtl/binning_top.sv
verification/binning_tb.sv

//--- Makefile
.PHONY: run clean

run: obj_dir/Vbinning_tb
	@out=$$(./obj_dir/Vbinning_tb); echo "$$out"; echo "$$out" | grep -qx "test passed"

obj_dir/Vbinning_tb: flist.f $(wildcard rtl/*.sv verification/*.sv)
	verilator --binary --timing -Wno-fatal --top-module binning_tb -f flist.f

clean:
	rm -rf obj_dir
